// ==== logic/tcpPkg.sv ====
package tcpPkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////
	localparam int byteW  = 8;
	localparam int ipW    = 32;
	localparam int portW  = 16;
	localparam int seqW   = 32;
	localparam int lenW   = 16;
	localparam int stateW = 6;
	localparam int fieldW = 3;

	//////////////////////////////////////////////////
	// parser states
	//////////////////////////////////////////////////
	localparam logic [stateW-1:0] sIdle     = 6'd0;	// waiting for newPkt
	localparam logic [stateW-1:0] sEthDst   = 6'd1;
	localparam logic [stateW-1:0] sEthSrc   = 6'd2;
	localparam logic [stateW-1:0] sEthType0 = 6'd3;	// high byte of ethertype or TPID
	localparam logic [stateW-1:0] sEthType1 = 6'd4;
	localparam logic [stateW-1:0] sVlan     = 6'd5;	// two byte 802.1Q TCI
	localparam logic [stateW-1:0] sIpHdr    = 6'd6;
	localparam logic [stateW-1:0] sIpOpt    = 6'd7;
	localparam logic [stateW-1:0] sTcpHdr   = 6'd8;
	localparam logic [stateW-1:0] sTcpOpt   = 6'd9;
	localparam logic [stateW-1:0] sPayload  = 6'd10;
	localparam logic [stateW-1:0] sDrop     = 6'd11;	// frame is not IPv4/TCP so wait for newPkt

	// header fields compared against the sessions
	localparam logic [fieldW-1:0] fieldNone    = 3'd0;
	localparam logic [fieldW-1:0] fieldSrcIp   = 3'd1;
	localparam logic [fieldW-1:0] fieldDstIp   = 3'd2;
	localparam logic [fieldW-1:0] fieldSrcPort = 3'd3;
	localparam logic [fieldW-1:0] fieldDstPort = 3'd4;

	//////////////////////////////////////////////////
	// protocol constants
	//////////////////////////////////////////////////
	localparam logic [15:0] ethTypeIpv4 = 16'h0800;
	localparam logic [15:0] ethTypeVlan = 16'h8100;
	localparam logic [7:0]  ipProtoTcp  = 8'h06;

	// IPv4 + TCP header bytes without any options
	localparam logic [lenW-1:0] ipTcpMinLen = 16'd40;

endpackage

// ==== logic/hdrIf.sv ====
interface hdrIf import tcpPkg::*; #(
	parameter int numSessions = 2
) ();

	logic [byteW-1:0]  byteData;
	logic              byteValid;
	logic [fieldW-1:0] field;	// header field of the current byte
	logic [1:0]        fieldIdx;	// byte within field counted msb first
	logic [seqW-1:0]   seqNum;
	logic              synFlag;
	logic              hdrEnd;	// last byte of TCP header incl. options
	logic [lenW-1:0]   payloadLen;
	logic              inPayload;

	// the session compare logic hangs off this bus
	if (numSessions < 1) begin : gSessCheck
		$error("hdrIf needs at least one session");
	end

	modport parser (output byteData, byteValid, field, fieldIdx, seqNum, synFlag,
		hdrEnd, payloadLen, inPayload);

	modport matcher (input byteData, byteValid, field, fieldIdx);

	modport tracker (input hdrEnd, seqNum, synFlag, payloadLen);

	modport emitter (input byteData, byteValid, hdrEnd, payloadLen, inPayload);

endinterface

// ==== logic/frameParser.sv ====
module frameParser import tcpPkg::*; (
	input  logic             CLOCK,
	input  logic             arstN,
	input  logic             newPkt,
	input  logic             dataValid,
	input  logic [byteW-1:0] data,
	hdrIf.parser             hdr
);

	logic [stateW-1:0] state;
	logic [4:0]        pos;	// byte position inside the current section
	logic [3:0]        optLeft;	// option words still to skip
	logic [lenW-1:0]   payLeft;
	logic [byteW-1:0]  typeHi;
	logic [3:0]        ihl;
	logic [3:0]        dataOff;
	logic [byteW-1:0]  proto;
	logic [lenW-1:0]   totLen;
	logic [seqW-1:0]   seqBuf;
	logic              syn;
	logic [lenW-1:0]   payLen;
	logic              take;
	logic              optDone;
	logic              tcpLast;

	// a byte arriving together with newPkt is not part of the frame
	assign take    = dataValid && !newPkt;
	assign optDone = (pos[1:0] == 2'd3) && (optLeft == 4'd1);
	assign payLen  = totLen - lenW'({ihl, 2'b00}) - lenW'({dataOff, 2'b00});

	always_comb begin
		tcpLast = 1'b0;
		if (state == sTcpHdr)
			tcpLast = (pos == 5'd19) && (dataOff <= 4'd5);
		else if (state == sTcpOpt)
			tcpLast = optDone;
	end

	assign hdr.byteData   = data;
	assign hdr.byteValid  = dataValid;
	assign hdr.seqNum     = seqBuf;
	assign hdr.synFlag    = syn;
	assign hdr.payloadLen = payLen;
	assign hdr.hdrEnd     = take && tcpLast;
	assign hdr.inPayload  = take && (state == sPayload);

	//////////////////////////////////////////////////
	// field strobes for the session compare
	//////////////////////////////////////////////////
	always_comb begin
		hdr.field    = fieldNone;
		hdr.fieldIdx = pos[1:0];
		if (!newPkt && state == sIpHdr) begin
			if (pos >= 5'd16)
				hdr.field = fieldDstIp;
			else if (pos >= 5'd12)
				hdr.field = fieldSrcIp;
		end else if (!newPkt && state == sTcpHdr && pos < 5'd4) begin
			hdr.field    = pos[1] ? fieldDstPort : fieldSrcPort;
			hdr.fieldIdx = {1'b0, pos[0]};
		end
	end

	//////////////////////////////////////////////////
	// header walk
	//////////////////////////////////////////////////
	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			state   <= sIdle;
			pos     <= '0;
			optLeft <= '0;
			payLeft <= '0;
		end else if (newPkt) begin
			state <= sEthDst;
			pos   <= '0;
		end else if (dataValid) begin
			pos <= pos + 5'd1;
			case (state)
				sEthDst, sEthSrc: if (pos == 5'd5) begin
					state <= (state == sEthDst) ? sEthSrc : sEthType0;
					pos   <= '0;
				end
				sEthType0: state <= sEthType1;
				sEthType1: begin
					pos <= '0;
					if ({typeHi, data} == ethTypeVlan)
						state <= sVlan;	// soak up the tag and read the ethertype after it
					else if ({typeHi, data} == ethTypeIpv4)
						state <= sIpHdr;
					else
						state <= sDrop;
				end
				sVlan: if (pos == 5'd1) begin
					state <= sEthType0;
					pos   <= '0;
				end
				sIpHdr: if (pos == 5'd19) begin
					pos <= '0;
					if (proto != ipProtoTcp || totLen < ipTcpMinLen)
						state <= sDrop;
					else if (ihl > 4'd5) begin
						state   <= sIpOpt;
						optLeft <= ihl - 4'd5;
					end else
						state <= sTcpHdr;
				end
				sIpOpt: if (pos[1:0] == 2'd3) begin
					optLeft <= optLeft - 4'd1;
					if (optLeft == 4'd1) begin
						state <= sTcpHdr;
						pos   <= '0;
					end
				end
				sTcpHdr: if (pos == 5'd19) begin
					pos <= '0;
					if (dataOff > 4'd5) begin
						state   <= sTcpOpt;
						optLeft <= dataOff - 4'd5;
					end else begin
						state   <= (payLen != '0) ? sPayload : sIdle;
						payLeft <= payLen;
					end
				end
				sTcpOpt: if (pos[1:0] == 2'd3) begin
					optLeft <= optLeft - 4'd1;
					if (optDone) begin
						state   <= (payLen != '0) ? sPayload : sIdle;
						payLeft <= payLen;
					end
				end
				sPayload: begin
					payLeft <= payLeft - 1'b1;
					if (payLeft == 1) state <= sIdle;	// padding after this is ignored
				end
				default: state <= state;	// idle and drop hold until newPkt
			endcase
		end
	end

	// header fields captured as they pass
	always_ff @(posedge CLOCK) begin
		if (take && state == sEthType0)
			typeHi <= data;
		if (take && state == sIpHdr) begin
			case (pos)
				5'd0:       ihl    <= data[3:0];
				5'd2, 5'd3: totLen <= {totLen[byteW-1:0], data};
				5'd9:       proto  <= data;
				default: ;
			endcase
		end
		if (take && state == sTcpHdr) begin
			case (pos)
				5'd4, 5'd5, 5'd6, 5'd7: seqBuf <= {seqBuf[seqW-byteW-1:0], data};
				5'd12: dataOff <= data[7:4];
				5'd13: syn     <= data[1];
				default: ;
			endcase
		end
	end

	assert property (@(posedge CLOCK) disable iff (!arstN)
		(state == sPayload) |-> (payLeft != '0))
		else $error("payload counter empty in payload state");

endmodule

// ==== logic/sessionMatch.sv ====
module sessionMatch import tcpPkg::*; #(
	parameter int numSessions = 2
) (
	input  logic                               CLOCK,
	input  logic                               arstN,
	hdrIf.matcher                              hdr,
	input  logic [numSessions-1:0][ipW-1:0]    srcIp,
	input  logic [numSessions-1:0][ipW-1:0]    dstIp,
	input  logic [numSessions-1:0][portW-1:0]  srcPort,
	input  logic [numSessions-1:0][portW-1:0]  dstPort,
	output logic [numSessions-1:0]             match
);

	localparam int flagW = 12;	// 4+4 address bytes, 2+2 port bytes

	for (genvar s = 0; s < numSessions; s++) begin : gSess
		logic [flagW-1:0] hit;
		logic [byteW-1:0] want;
		logic [3:0]       bitSel;

		// session byte that lines up with the current header byte
		always_comb begin
			want   = '0;
			bitSel = '0;
			case (hdr.field)
				fieldSrcIp: begin
					want   = srcIp[s][(3 - hdr.fieldIdx) * byteW +: byteW];
					bitSel = {2'b00, hdr.fieldIdx};
				end
				fieldDstIp: begin
					want   = dstIp[s][(3 - hdr.fieldIdx) * byteW +: byteW];
					bitSel = {2'b01, hdr.fieldIdx};
				end
				fieldSrcPort: begin
					want   = srcPort[s][(1 - hdr.fieldIdx[0]) * byteW +: byteW];
					bitSel = {3'b100, hdr.fieldIdx[0]};
				end
				fieldDstPort: begin
					want   = dstPort[s][(1 - hdr.fieldIdx[0]) * byteW +: byteW];
					bitSel = {3'b101, hdr.fieldIdx[0]};
				end
				default: ;
			endcase
		end

		always_ff @(posedge CLOCK or negedge arstN) begin
			if (!arstN)
				hit <= '0;
			else if (hdr.byteValid && hdr.field != fieldNone)
				hit[bitSel] <= (hdr.byteData == want);	// each frame rewrites every bit
		end

		assign match[s] = &hit;
	end

endmodule

// ==== logic/seqTracker.sv ====
module seqTracker import tcpPkg::*; #(
	parameter int numSessions = 2
) (
	input  logic                   CLOCK,
	input  logic                   arstN,
	hdrIf.tracker                  hdr,
	input  logic [numSessions-1:0] match,
	output logic [numSessions-1:0] gapped
);

	logic [numSessions-1:0][seqW-1:0] expected;	// next in-order seq per session
	logic [seqW-1:0]                  segEnd;

	assign segEnd = hdr.seqNum + {{(seqW-lenW){1'b0}}, hdr.payloadLen};

	//////////////////////////////////////////////////
	// per-session sequence follow
	//////////////////////////////////////////////////
	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			expected <= '0;
			gapped   <= '0;
		end else if (hdr.hdrEnd) begin
			for (int s = 0; s < numSessions; s++) begin
				if (match[s] && hdr.synFlag) begin
					// SYN takes one sequence number
					expected[s] <= hdr.seqNum + 1'b1;
					gapped[s]   <= 1'b0;
				end else if (match[s]) begin
					gapped[s]   <= (hdr.seqNum != expected[s]);
					expected[s] <= segEnd;
				end
			end
		end
	end

	// one strobe per frame at the end of the header
	assert property (@(posedge CLOCK) disable iff (!arstN)
		hdr.hdrEnd |=> !hdr.hdrEnd)
		else $error("hdrEnd high on consecutive cycles");

endmodule

// ==== logic/payloadOut.sv ====
module payloadOut import tcpPkg::*; #(
	parameter int numSessions = 2
) (
	input  logic                   CLOCK,
	input  logic                   arstN,
	hdrIf.emitter                  hdr,
	input  logic [numSessions-1:0] match,
	output logic [byteW-1:0]       outData,
	output logic                   outPayload,
	output logic                   outNewPkt,
	output logic [numSessions-1:0] outMatch
);

	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			outPayload <= 1'b0;
			outNewPkt  <= 1'b0;
			outMatch   <= '0;
		end else begin
			outPayload <= hdr.inPayload;
			outNewPkt  <= hdr.hdrEnd && (hdr.payloadLen != '0);	// no pulse for bare acks
			outMatch   <= hdr.inPayload ? match : '0;
		end
	end

	always_ff @(posedge CLOCK) begin
		if (hdr.byteValid)
			outData <= hdr.byteData;
	end

	// match flags must hold steady over the whole payload
	assert property (@(posedge CLOCK) disable iff (!arstN)
		hdr.inPayload |-> $stable(match))
		else $error("match changed during a payload");

endmodule

// ==== logic/tcpStream.sv ====
module tcpStream import tcpPkg::*; #(
	parameter int numSessions = 2
) (
	input  logic                               CLOCK,
	input  logic                               arstN,
	input  logic                               newPkt,
	input  logic                               dataValid,
	input  logic [byteW-1:0]                   data,
	input  logic [numSessions-1:0][ipW-1:0]    srcIp,
	input  logic [numSessions-1:0][ipW-1:0]    dstIp,
	input  logic [numSessions-1:0][portW-1:0]  srcPort,
	input  logic [numSessions-1:0][portW-1:0]  dstPort,
	output logic [byteW-1:0]                   outData,
	output logic                               outPayload,
	output logic                               outNewPkt,
	output logic [numSessions-1:0]             outMatch,
	output logic [numSessions-1:0]             gapped
);

	logic [numSessions-1:0] match;	// valid from dst port until next frame

	hdrIf #(.numSessions(numSessions)) hdrBus ();

	frameParser u_parser (
		.CLOCK, .arstN, .newPkt, .dataValid, .data,
		.hdr (hdrBus.parser)
	);

	sessionMatch #(.numSessions(numSessions)) u_match (
		.CLOCK, .arstN,
		.hdr (hdrBus.matcher),
		.srcIp, .dstIp, .srcPort, .dstPort,
		.match
	);

	seqTracker #(.numSessions(numSessions)) u_tracker (
		.CLOCK, .arstN,
		.hdr (hdrBus.tracker),
		.match, .gapped
	);

	payloadOut #(.numSessions(numSessions)) u_out (
		.CLOCK, .arstN,
		.hdr (hdrBus.emitter),
		.match, .outData, .outPayload, .outNewPkt, .outMatch
	);

endmodule

// ==== include/tbFrames.svh ====
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// name, session (0 A, 1 B, 2 neither), vlan, ip option words, tcp option words,
// ethertype, protocol, syn, seq, payload bytes, expected gapped {B, A}
task automatic buildTable();
	addRow("synA",      0, 0, 0, 0, 16'h0800, 8'h06, 1, 32'd1000, 0,  2'b00);
	addRow("dataA",     0, 0, 0, 0, 16'h0800, 8'h06, 0, 32'd1001, 16, 2'b00);
	addRow("optsA",     0, 0, 2, 3, 16'h0800, 8'h06, 0, 32'd1017, 20, 2'b00);
	addRow("vlanA",     0, 1, 1, 0, 16'h0800, 8'h06, 0, 32'd1037, 8,  2'b00);
	addRow("synB",      1, 0, 0, 0, 16'h0800, 8'h06, 1, 32'd5000, 0,  2'b00);
	addRow("vlanOptB",  1, 1, 0, 2, 16'h0800, 8'h06, 0, 32'd5001, 12, 2'b00);
	addRow("skipA",     0, 0, 0, 0, 16'h0800, 8'h06, 0, 32'd1100, 10, 2'b01);
	addRow("ipv6",      0, 0, 0, 0, 16'h86DD, 8'h06, 0, 32'd1110, 10, 2'b01);
	addRow("udp",       0, 0, 0, 0, 16'h0800, 8'h11, 0, 32'd1110, 10, 2'b01);
	addRow("neither",   2, 0, 0, 0, 16'h0800, 8'h06, 0, 32'd7,    9,  2'b01);
	addRow("inOrderA",  0, 0, 0, 1, 16'h0800, 8'h06, 0, 32'd1110, 5,  2'b00);
	addRow("skipB",     1, 0, 0, 0, 16'h0800, 8'h06, 0, 32'd6000, 6,  2'b10);
	addRow("ackB",      1, 0, 0, 0, 16'h0800, 8'h06, 0, 32'd6006, 0,  2'b00);
	addRow("skipB2",    1, 0, 1, 1, 16'h0800, 8'h06, 0, 32'd7000, 4,  2'b10);
	addRow("resynB",    1, 0, 0, 0, 16'h0800, 8'h06, 1, 32'd9000, 0,  2'b00);
	addRow("vlanArp",   0, 1, 0, 0, 16'h0806, 8'h06, 0, 32'd1115, 7,  2'b00);
endtask

`endif

// ==== dv/tbTcpStream.sv ====
module tbTcpStream import tcpPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct {
		string       name;
		int          sess;	// 0 A, 1 B, 2 neither
		bit          vlan;
		int          ipOpt;	// option words
		int          tcpOpt;
		logic [15:0] ethType;
		logic [7:0]  proto;
		bit          syn;
		logic [31:0] seq;
		int          payLen;
		logic [1:0]  expGap;	// {B, A} after the frame
	} frameT;

	logic                  CLOCK;
	logic                  arstN;
	logic                  newPkt;
	logic                  dataValid;
	logic [byteW-1:0]      data;
	logic [1:0][ipW-1:0]   srcIp;
	logic [1:0][ipW-1:0]   dstIp;
	logic [1:0][portW-1:0] srcPort;
	logic [1:0][portW-1:0] dstPort;
	logic [byteW-1:0]      outData;
	logic                  outPayload;
	logic                  outNewPkt;
	logic [1:0]            outMatch;
	logic [1:0]            gapped;

	frameT            frames[$];
	logic [byteW-1:0] frameBytes[$];
	logic [byteW-1:0] expPay[$];
	logic [byteW-1:0] gotData[$];
	logic [1:0]       gotMatch[$];
	int               newPktSeen;
	int               errCount;
	int               timeoutCount;
	logic [31:0]      rngState;

	tcpStream #(.numSessions(2)) u_dut (
		.CLOCK, .arstN, .newPkt, .dataValid, .data,
		.srcIp, .dstIp, .srcPort, .dstPort,
		.outData, .outPayload, .outNewPkt, .outMatch, .gapped
	);

	initial begin
		CLOCK = 1'b0;
		forever #50 CLOCK = ~CLOCK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic checkVal(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errCount++;
			$display("ERR %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic addRow(input string name, input int sess, input bit vlan, input int ipOpt,
			input int tcpOpt, input logic [15:0] ethType, input logic [7:0] proto,
			input bit syn, input logic [31:0] seq, input int payLen, input logic [1:0] expGap);
		frameT r;
		r = '{name, sess, vlan, ipOpt, tcpOpt, ethType, proto, syn, seq, payLen, expGap};
		frames.push_back(r);
	endtask

	`include "tbFrames.svh"

	task automatic pushBytes(input logic [31:0] w, input int n);
		for (int i = 0; i < n; i++)
			frameBytes.push_back(w[31 - 8 * i -: 8]);	// msb first
	endtask

	//////////////////////////////////////////////////
	// frame builder
	//////////////////////////////////////////////////
	task automatic buildFrame(input frameT r);
		logic [15:0] sPort;
		logic [15:0] dPort;
		int          idx;
		int          totLen;
		bit          isTcp;
		frameBytes.delete();
		expPay.delete();
		idx    = (r.sess == 1) ? 1 : 0;
		sPort  = (r.sess == 2) ? 16'h270F : srcPort[idx];	// foreign ports when neither matches
		dPort  = (r.sess == 2) ? 16'h1F90 : dstPort[idx];
		isTcp  = (r.ethType == 16'h0800) && (r.proto == 8'h06);
		totLen = 4 * (5 + r.ipOpt) + 4 * (5 + r.tcpOpt) + r.payLen;
		for (int i = 0; i < 12; i++)
			frameBytes.push_back(8'(8'h20 + i));	// dst and src mac
		if (r.vlan)
			pushBytes(32'h8100_2005, 4);
		pushBytes({r.ethType, 16'h0000}, 2);
		pushBytes({4'h4, 4'(5 + r.ipOpt), 8'h00, 16'(totLen)}, 4);
		pushBytes(32'h1234_4000, 4);
		pushBytes({8'h40, r.proto, 16'h0000}, 4);	// ttl, protocol, checksum
		pushBytes(srcIp[idx], 4);
		pushBytes(dstIp[idx], 4);
		repeat (r.ipOpt) pushBytes(32'h0101_0101, 4);
		pushBytes({sPort, dPort}, 4);
		pushBytes(r.seq, 4);
		pushBytes(32'h0000_0000, 4);
		pushBytes({4'(5 + r.tcpOpt), 4'h0, (r.syn ? 8'h02 : 8'h10), 16'hFFFF}, 4);
		pushBytes(32'h0000_0000, 4);
		repeat (r.tcpOpt) pushBytes(32'h0101_0101, 4);
		for (int i = 0; i < r.payLen; i++) begin
			rngState = xorshift(rngState);
			frameBytes.push_back(rngState[7:0]);
			if (isTcp)
				expPay.push_back(rngState[7:0]);
		end
		rngState = xorshift(rngState);
		repeat (1 + rngState[1:0]) frameBytes.push_back(8'hEE);	// ethernet padding
	endtask

	task automatic driveFrame();
		int idle;
		@(posedge CLOCK);
		#1 newPkt = 1'b1;
		@(posedge CLOCK);
		#1 newPkt = 1'b0;
		foreach (frameBytes[i]) begin
			rngState  = xorshift(rngState);
			idle      = (rngState[4:2] == 3'd0) ? 1 + rngState[6:5] : 0;
			dataValid = 1'b0;
			repeat (idle) begin
				@(posedge CLOCK);
				#1;
			end
			dataValid = 1'b1;
			data      = frameBytes[i];
			@(posedge CLOCK);
			#1;
		end
		dataValid = 1'b0;
	endtask

	// output beats taken mid-cycle
	always @(negedge CLOCK) begin
		if (arstN && outPayload) begin
			gotData.push_back(outData);
			gotMatch.push_back(outMatch);
		end
		if (arstN && outNewPkt)
			newPktSeen++;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int         waitCycles;
		logic [1:0] expMatch;
		string      tn;
		arstN        = 1'b0;
		newPkt       = 1'b0;
		dataValid    = 1'b0;
		data         = '0;
		srcIp        = {32'hC0A8_0105, 32'h0A00_0001};	// {B, A}
		dstIp        = {32'hC0A8_0109, 32'h0A00_0002};
		srcPort      = {16'hC350, 16'h03E8};
		dstPort      = {16'h01BB, 16'h0050};
		errCount     = 0;
		timeoutCount = 0;
		newPktSeen   = 0;
		rngState     = 32'h1545_4174;
		buildTable();
		repeat (5) @(posedge CLOCK);
		checkVal("reset outputs", '0, {outPayload, outNewPkt, outMatch, gapped});
		#1 arstN = 1'b1;
		foreach (frames[k]) begin
			tn = frames[k].name;
			buildFrame(frames[k]);
			gotData.delete();
			gotMatch.delete();
			newPktSeen = 0;
			driveFrame();
			waitCycles = 0;
			while (gotData.size() < expPay.size() && waitCycles < 40) begin
				@(posedge CLOCK);
				waitCycles++;
			end
			if (gotData.size() < expPay.size()) begin
				timeoutCount++;
				$display("timeout in %s: fewer payload beats came out than were sent", tn);
			end
			repeat (2) @(posedge CLOCK);
			expMatch = (frames[k].sess == 2) ? 2'b00 : 2'(1 << frames[k].sess);
			checkVal({tn, " beats"}, expPay.size(), gotData.size());
			for (int i = 0; i < expPay.size() && i < gotData.size(); i++) begin
				checkVal($sformatf("%s data[%0d]", tn, i), expPay[i], gotData[i]);
				checkVal($sformatf("%s match[%0d]", tn, i), expMatch, gotMatch[i]);
			end
			checkVal({tn, " newPkt"}, (expPay.size() != 0) ? 1 : 0, newPktSeen);
			checkVal({tn, " gapped"}, frames[k].expGap, gapped);
		end
		$display("errors %0d, timeouts %0d", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
logic/tcpPkg.sv
logic/hdrIf.sv
logic/frameParser.sv
logic/sessionMatch.sv
logic/seqTracker.sv
logic/payloadOut.sv
logic/tcpStream.sv
dv/tbTcpStream.sv
